// ==== hdl/rv_consts.svh ====
// widths, opcodes and constants for the RV32I subset core
// only the opcodes and funct3 codes listed here are decoded
// HALT_REG and HALT_CODE follow the usual exit ecall convention
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN         32
`define REG_ADDR_W   5

// major opcodes
`define OP_ARITH     7'b0110011
`define OP_ARITH_IMM 7'b0010011
`define OP_LOAD      7'b0000011
`define OP_STORE     7'b0100011
`define OP_SYSTEM    7'b1110011

`define F3_ADD       3'b000
`define F3_SLL       3'b001
`define F3_SLT       3'b010
`define F3_XOR       3'b100
`define F3_SRL       3'b101
`define F3_OR        3'b110
`define F3_AND       3'b111
`define F7_ALT_BIT   30 // inst bit that turns add into sub

`define HALT_REG     5'd17
`define HALT_CODE    32'd10
`define PC_STEP      32'd4
`define RESET_PC     32'h0000_0000

`endif

// ==== hdl/rv_pkg.sv ====
// shared types of the pipeline
// a bubble is any stage register whose control bits are all zero
`default_nettype none
`include "rv_consts.svh"

package rv_pkg;

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLL = 4'd5,
    ALU_SRL = 4'd6,
    ALU_SLT = 4'd7
  } alu_op_e;

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    alu_src;   // second operand is the immediate
    logic    is_ecall;
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    ctrl_t                  ctrl;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`XLEN-1:0]       imm;
  } id_ex_t;

  // also used for MEM/WB, alu_out then holds the writeback value
  typedef struct packed {
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
    logic                   mem_to_reg;
    logic                   halt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       alu_out;
    logic [`XLEN-1:0]       store_data;
  } ex_mem_t;

endpackage

`default_nettype wire

// ==== hdl/bypass_if.sv ====
// results of the two later stages, for forwarding and register write
`default_nettype none
`include "rv_consts.svh"

interface bypass_if;
  logic                   ex_mem_reg_write;
  logic [`REG_ADDR_W-1:0] ex_mem_rd;
  logic [`XLEN-1:0]       ex_mem_value;  // alu result, never load data
  logic                   wb_reg_write;
  logic [`REG_ADDR_W-1:0] wb_rd;
  logic [`XLEN-1:0]       wb_value;      // final writeback data

  modport producer (output ex_mem_reg_write, ex_mem_rd, ex_mem_value,
                    output wb_reg_write, wb_rd, wb_value);
  modport consumer (input ex_mem_reg_write, ex_mem_rd, ex_mem_value,
                    input wb_reg_write, wb_rd, wb_value);
endinterface

`default_nettype wire

// ==== hdl/regfile.sv ====
// 32 x XLEN register file, x0 hardwired to zero
// combinational reads, a read of the register being written sees wdata
`default_nettype none
`include "rv_consts.svh"

module regfile (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`REG_ADDR_W-1:0] rs1,
  input  logic [`REG_ADDR_W-1:0] rs2,
  input  logic [`REG_ADDR_W-1:0] rd,
  input  logic [`XLEN-1:0]       wdata,
  input  logic                   we,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data
);
  localparam int NREGS = 1 << `REG_ADDR_W;

  logic [`XLEN-1:0] regs [NREGS];
  logic             wr_en;

  assign wr_en = we && (rd != '0); // writes to x0 dropped

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = (wr_en && rd == rs1) ? wdata : regs[rs1];
  assign rs2_data = (wr_en && rd == rs2) ? wdata : regs[rs2];

  // x0 must read zero even with write-through active
  x0_reads_zero: assert property (@(posedge clk) disable iff (reset)
    (rs1 == '0) |-> (rs1_data == '0));

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
// decode, immediate generation, load-use hazard and the ID/EX register
// unknown opcodes decode to a bubble; the system opcode is taken as ECALL
// register file write port is fed from the writeback side of bypass_if
`default_nettype none
`include "rv_consts.svh"

module decode_stage (
  input  logic             clk,
  input  logic             reset,
  input  logic [`XLEN-1:0] inst,
  input  logic             halt_req,
  bypass_if.consumer       byp,
  output logic             stall,
  output rv_pkg::id_ex_t   id_ex
);
  import rv_pkg::*;

  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [`REG_ADDR_W-1:0] rs1_idx;
  logic [`REG_ADDR_W-1:0] rs2_idx;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;
  logic [`XLEN-1:0]       imm;
  ctrl_t                  ctrl;
  logic                   valid;
  logic                   uses_rs1;
  logic                   uses_rs2;
  logic                   bubble;

  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic sub);
    case (f3)
      `F3_ADD: alu_sel = sub ? ALU_SUB : ALU_ADD;
      `F3_SLL: alu_sel = ALU_SLL;
      `F3_SLT: alu_sel = ALU_SLT;
      `F3_XOR: alu_sel = ALU_XOR;
      `F3_SRL: alu_sel = ALU_SRL;
      `F3_OR:  alu_sel = ALU_OR;
      `F3_AND: alu_sel = ALU_AND;
      default: alu_sel = ALU_ADD;
    endcase
  endfunction

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  always_comb begin
    ctrl     = '0;
    valid    = 1'b1;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    imm      = {{(`XLEN-12){inst[31]}}, inst[31:20]}; // I form
    case (opcode)
      `OP_ARITH: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_sel(funct3, inst[`F7_ALT_BIT]);
        uses_rs1       = 1'b1;
        uses_rs2       = 1'b1;
      end
      `OP_ARITH_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = alu_sel(funct3, 1'b0); // bit 30 is immediate here
        uses_rs1       = 1'b1;
      end
      `OP_LOAD: begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src    = 1'b1;
        uses_rs1        = 1'b1;
      end
      `OP_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        imm            = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
        uses_rs1       = 1'b1;
        uses_rs2       = 1'b1;
      end
      `OP_SYSTEM: begin
        ctrl.is_ecall = 1'b1;
        uses_rs1      = 1'b1; // reads x17, may need forwarding or a stall
      end
      default: valid = 1'b0;
    endcase
  end

  // ecall reads x17 so the forwarding path supplies its current value
  assign rs1_idx = (opcode == `OP_SYSTEM) ? `HALT_REG : inst[19:15];
  assign rs2_idx = uses_rs2 ? inst[24:20] : '0;

  regfile rf (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1_idx),
    .rs2      (rs2_idx),
    .rd       (byp.wb_rd),
    .wdata    (byp.wb_value),
    .we       (byp.wb_reg_write),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // load in EX whose result is needed right now
  assign stall = id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
                 ((uses_rs1 && rs1_idx == id_ex.rd) || (uses_rs2 && rs2_idx == id_ex.rd));
  assign bubble = stall || halt_req || !valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex <= '0;
    end else begin
      id_ex.ctrl     <= bubble ? ctrl_t'('0) : ctrl;
      id_ex.rs1      <= rs1_idx;
      id_ex.rs2      <= rs2_idx;
      id_ex.rd       <= inst[11:7];
      id_ex.rs1_data <= rs1_data;
      id_ex.rs2_data <= rs2_data;
      id_ex.imm      <= imm;
    end
  end

  // the bubble loaded on a stall clears the hazard next cycle
  stall_one_cycle: assert property (@(posedge clk) disable iff (reset)
    stall |=> !stall);

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
// forwarding, ALU, store data and halt detection; purely combinational
// apart from the sticky halt_pending flag
// EX/MEM wins over MEM/WB, x0 is never forwarded
`default_nettype none
`include "rv_consts.svh"

module execute_stage (
  input  logic            clk,
  input  logic            reset,
  input  rv_pkg::id_ex_t  id_ex,
  bypass_if.consumer      byp,
  output rv_pkg::ex_mem_t ex_mem,
  output logic            halt_req
);
  import rv_pkg::*;

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] rs2_fwd;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_out;
  logic             halt_hit;
  logic             halt_pending;

  always_comb begin
    op_a = id_ex.rs1_data;
    if (byp.ex_mem_reg_write && byp.ex_mem_rd == id_ex.rs1 && id_ex.rs1 != '0) begin
      op_a = byp.ex_mem_value;
    end else if (byp.wb_reg_write && byp.wb_rd == id_ex.rs1 && id_ex.rs1 != '0) begin
      op_a = byp.wb_value;
    end
  end

  always_comb begin
    rs2_fwd = id_ex.rs2_data;
    if (byp.ex_mem_reg_write && byp.ex_mem_rd == id_ex.rs2 && id_ex.rs2 != '0) begin
      rs2_fwd = byp.ex_mem_value;
    end else if (byp.wb_reg_write && byp.wb_rd == id_ex.rs2 && id_ex.rs2 != '0) begin
      rs2_fwd = byp.wb_value;
    end
  end

  assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : rs2_fwd;

  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_SUB: alu_out = op_a - op_b;
      ALU_AND: alu_out = op_a & op_b;
      ALU_OR:  alu_out = op_a | op_b;
      ALU_XOR: alu_out = op_a ^ op_b;
      ALU_SLL: alu_out = op_a << op_b[4:0];
      ALU_SRL: alu_out = op_a >> op_b[4:0];
      ALU_SLT: alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_out = op_a + op_b; // add, also address calc
    endcase
  end

  // ecall with x17 == exit code
  assign halt_hit = id_ex.ctrl.is_ecall && (op_a == `HALT_CODE);

  always_ff @(posedge clk) begin
    if (reset) begin
      halt_pending <= 1'b0;
    end else if (halt_hit) begin
      halt_pending <= 1'b1;
    end
  end

  assign halt_req = halt_pending || halt_hit;

  always_comb begin
    ex_mem.reg_write  = id_ex.ctrl.reg_write;
    ex_mem.mem_read   = id_ex.ctrl.mem_read;
    ex_mem.mem_write  = id_ex.ctrl.mem_write;
    ex_mem.mem_to_reg = id_ex.ctrl.mem_to_reg;
    ex_mem.halt       = halt_hit;
    ex_mem.rd         = id_ex.rd;
    ex_mem.alu_out    = alu_out;
    ex_mem.store_data = rs2_fwd;
  end

  // decode must keep feeding bubbles once the halt is latched
  no_store_after_halt: assert property (@(posedge clk) disable iff (reset)
    halt_pending |-> !id_ex.ctrl.mem_write);

endmodule

`default_nettype wire

// ==== hdl/rv_core.sv ====
// five stage RV32I subset core, no control flow instructions
// instruction and data memories are external with zero-wait combinational reads
// is_halted stays high until reset once a halting ECALL retires
`default_nettype none
`include "rv_consts.svh"

module rv_core (
  input  logic             clk,
  input  logic             reset,
  output logic [`XLEN-1:0] imem_addr,
  input  logic [`XLEN-1:0] imem_data,
  output logic [`XLEN-1:0] dmem_addr,
  output logic [`XLEN-1:0] dmem_wdata,
  output logic             dmem_we,
  output logic             dmem_re,
  input  logic [`XLEN-1:0] dmem_rdata,
  output logic             is_halted
);
  import rv_pkg::*;

  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] if_id_inst;
  logic             stall;
  logic             halt_req;
  logic             hold;
  id_ex_t           id_ex;
  ex_mem_t          ex_mem_d;
  ex_mem_t          ex_mem_q;
  ex_mem_t          mem_wb;
  logic [`XLEN-1:0] mem_value;

  bypass_if byp ();

  assign hold = stall || halt_req; // freeze fetch and IF/ID

  always_ff @(posedge clk) begin
    if (reset) begin
      pc         <= `RESET_PC;
      if_id_inst <= '0; // opcode 0 decodes as a bubble
    end else if (!hold) begin
      pc         <= pc + `PC_STEP;
      if_id_inst <= imem_data;
    end
  end

  assign imem_addr = pc;

  decode_stage u_decode (
    .clk      (clk),
    .reset    (reset),
    .inst     (if_id_inst),
    .halt_req (halt_req),
    .byp      (byp),
    .stall    (stall),
    .id_ex    (id_ex)
  );

  execute_stage u_execute (
    .clk      (clk),
    .reset    (reset),
    .id_ex    (id_ex),
    .byp      (byp),
    .ex_mem   (ex_mem_d),
    .halt_req (halt_req)
  );

  // memory stage
  assign dmem_addr  = ex_mem_q.alu_out;
  assign dmem_wdata = ex_mem_q.store_data;
  assign dmem_we    = ex_mem_q.mem_write;
  assign dmem_re    = ex_mem_q.mem_read;
  assign mem_value  = ex_mem_q.mem_to_reg ? dmem_rdata : ex_mem_q.alu_out;

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem_q  <= '0;
      mem_wb    <= '0;
      is_halted <= 1'b0;
    end else begin
      ex_mem_q       <= ex_mem_d;
      mem_wb         <= ex_mem_q;
      mem_wb.alu_out <= mem_value; // writeback value from here on
      if (mem_wb.halt) begin
        is_halted <= 1'b1;
      end
    end
  end

  assign byp.ex_mem_reg_write = ex_mem_q.reg_write;
  assign byp.ex_mem_rd        = ex_mem_q.rd;
  assign byp.ex_mem_value     = ex_mem_q.alu_out;
  assign byp.wb_reg_write     = mem_wb.reg_write;
  assign byp.wb_rd            = mem_wb.rd;
  assign byp.wb_value         = mem_wb.alu_out;

endmodule

`default_nettype wire

// ==== dv/rv_checker.sv ====
// watches the data port and halt level of rv_core
// expected stores are queued per test, compared in order at the falling edge
// reset state is checked while reset is applied and for two cycles after
`default_nettype none
`include "rv_consts.svh"

module rv_checker (
  input logic             clk,
  input logic             reset,
  input logic [`XLEN-1:0] imem_addr,
  input logic [`XLEN-1:0] dmem_addr,
  input logic [`XLEN-1:0] dmem_wdata,
  input logic             dmem_we,
  input logic             dmem_re,
  input logic             is_halted
);
  logic [`XLEN-1:0] exp_addr [$];
  logic [`XLEN-1:0] exp_data [$];
  string            test_name = "";
  int               test_errors = 0;
  int               err_total = 0;
  int               tests_run = 0;
  int               tests_failed = 0;
  logic             reset_seen = 1'b0;
  int               cycles_out = 8; // no early checks before the first reset

  task count_error();
    test_errors++;
    err_total++;
  endtask

  task check_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, sig, got, exp);
      count_error();
    end
  endtask

  task start_test(input string name);
    test_name   = name;
    test_errors = 0;
    exp_addr.delete();
    exp_data.delete();
  endtask

  task add_expected(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task compare_store();
    logic [31:0] a;
    logic [31:0] d;
    if (exp_addr.size() == 0) begin
      $display("%s: unexpected store of %h to %h at %0t", test_name, dmem_wdata,
               dmem_addr, $time);
      count_error();
    end else begin
      a = exp_addr.pop_front();
      d = exp_data.pop_front();
      check_value("dmem_addr", dmem_addr, a);
      check_value("dmem_wdata", dmem_wdata, d);
    end
  endtask

  task end_test(input logic exp_halt);
    if (exp_addr.size() != 0) begin
      $display("%s: %0d expected stores never reached the data port", test_name,
               exp_addr.size());
      count_error();
    end
    check_value("is_halted", 32'(is_halted), 32'(exp_halt));
    tests_run++;
    if (test_errors == 0) begin
      $display("test %-20s ok", test_name);
    end else begin
      tests_failed++;
      $display("test %-20s FAILED with %0d errors", test_name, test_errors);
    end
  endtask

  task report_counts();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             err_total);
  endtask

  function int errors_total();
    return err_total;
  endfunction

  // how long since reset dropped, saturating
  always @(posedge clk) begin
    reset_seen <= reset;
    if (reset) begin
      cycles_out <= 0;
    end else if (cycles_out < 8) begin
      cycles_out <= cycles_out + 1;
    end
  end

  always @(negedge clk) begin
    if (reset_seen) begin
      check_value("imem_addr", imem_addr, `RESET_PC);
      check_value("dmem_we", 32'(dmem_we), 32'd0);
      check_value("dmem_re", 32'(dmem_re), 32'd0);
      check_value("is_halted", 32'(is_halted), 32'd0);
    end else begin
      if (cycles_out <= 2) begin // first instruction not yet in MEM
        check_value("dmem_we", 32'(dmem_we), 32'd0);
        check_value("dmem_re", 32'(dmem_re), 32'd0);
        check_value("is_halted", 32'(is_halted), 32'd0);
      end
      if (dmem_we) begin
        compare_store();
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_top.sv ====
// testbench for rv_core with zero-wait instruction and data memories
// programs are straight-line code, each ends with register dump stores and an exit ecall
// data memory covers 1 KB, addresses wrap above that
`default_nettype none
`include "rv_consts.svh"

module tb_top;
  localparam int IMEM_WORDS = 256;
  localparam int DMEM_WORDS = 256;
  localparam int TIMEOUT    = 400;

  logic             clk;
  logic             reset;
  logic [`XLEN-1:0] imem_addr;
  logic [`XLEN-1:0] imem_data;
  logic [`XLEN-1:0] dmem_addr;
  logic [`XLEN-1:0] dmem_wdata;
  logic             dmem_we;
  logic             dmem_re;
  logic [`XLEN-1:0] dmem_rdata;
  logic             is_halted;

  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] dmem [DMEM_WORDS];
  logic [31:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] lfsr_state = 32'heb3e_2cb4;

  rv_core dut0 (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_re    (dmem_re),
    .dmem_rdata (dmem_rdata),
    .is_halted  (is_halted)
  );

  rv_checker chk0 (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_re    (dmem_re),
    .is_halted  (is_halted)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  // initial data memory contents, a hash of the byte address
  function automatic logic [31:0] fill_word(input int idx);
    logic [31:0] a;
    a = idx * 4;
    return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
  endfunction

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic int pick_reg();
    return int'(rand_bits(3)) % 7 + 1; // x1 to x7
  endfunction

  function automatic logic [31:0] r_type(input logic [2:0] f3, input logic alt,
                                         input int rd, input int rs1, input int rs2);
    return {1'b0, alt, 5'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], `OP_ARITH};
  endfunction

  function automatic logic [31:0] i_type(input logic [2:0] f3, input int rd, input int rs1,
                                         input int imm, input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `OP_STORE};
  endfunction

  task emit(input logic [31:0] w);
    prog.push_back(w);
  endtask

  // ISA level model, fills exp_addr/exp_data and tells whether the program halts
  function automatic logic reference_run();
    logic [31:0] regs [32];
    logic [31:0] mem [DMEM_WORDS];
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic [6:0]  op;
    logic [4:0]  rd;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      mem[i] = fill_word(i);
    end
    exp_addr.delete();
    exp_data.delete();
    for (int k = 0; k < prog.size(); k++) begin
      inst = prog[k];
      op   = inst[6:0];
      rd   = inst[11:7];
      a    = regs[inst[19:15]];
      b    = regs[inst[24:20]];
      case (op)
        `OP_ARITH, `OP_ARITH_IMM: begin
          if (op == `OP_ARITH_IMM) begin
            b = {{20{inst[31]}}, inst[31:20]};
          end
          case (inst[14:12])
            `F3_ADD: res = (op == `OP_ARITH && inst[30]) ? a - b : a + b;
            `F3_SLL: res = a << b[4:0];
            `F3_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `F3_XOR: res = a ^ b;
            `F3_SRL: res = a >> b[4:0];
            `F3_OR:  res = a | b;
            default: res = a & b;
          endcase
          if (rd != 0) begin
            regs[rd] = res;
          end
        end
        `OP_LOAD: begin
          addr = a + {{20{inst[31]}}, inst[31:20]};
          if (rd != 0) begin
            regs[rd] = mem[addr[9:2]];
          end
        end
        `OP_STORE: begin
          addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
          mem[addr[9:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        `OP_SYSTEM: begin
          if (regs[`HALT_REG] == `HALT_CODE) begin
            return 1'b1;
          end
        end
        default: ;
      endcase
    end
    return 1'b0;
  endfunction

  // dump x1..x7, exit ecall, then a store that must never issue
  task append_epilogue();
    for (int r = 1; r <= 7; r++) begin
      emit(s_type(r, 0, 32'h200 + 4 * r));
    end
    emit(i_type(`F3_ADD, 17, 0, 10, `OP_ARITH_IMM));
    emit(32'h0000_0073);
    emit(s_type(2, 0, 32'h300));
  endtask

  task reset_program();
    prog.delete();
    emit(i_type(`F3_ADD, 1, 0, 1, `OP_ARITH_IMM));
    append_epilogue();
  endtask

  // each result feeds the next one or two instructions
  task chain_program();
    prog.delete();
    emit(i_type(`F3_ADD, 1, 0, 'h5a3, `OP_ARITH_IMM));
    emit(i_type(`F3_ADD, 2, 0, -77, `OP_ARITH_IMM));
    emit(r_type(`F3_ADD, 1'b0, 3, 1, 2));
    emit(r_type(`F3_ADD, 1'b1, 4, 3, 1));  // sub
    emit(r_type(`F3_SLL, 1'b0, 5, 4, 2));
    emit(r_type(`F3_SRL, 1'b0, 6, 5, 3));
    emit(r_type(`F3_SLT, 1'b0, 7, 6, 5));
    emit(r_type(`F3_AND, 1'b0, 1, 7, 6));
    emit(r_type(`F3_OR, 1'b0, 2, 1, 4));
    emit(r_type(`F3_XOR, 1'b0, 3, 2, 1));
    emit(i_type(`F3_AND, 4, 3, 'h0f0, `OP_ARITH_IMM));
    emit(i_type(`F3_OR, 5, 4, -256, `OP_ARITH_IMM));
    emit(i_type(`F3_XOR, 6, 5, 'h555, `OP_ARITH_IMM));
    emit(r_type(`F3_SLT, 1'b0, 7, 2, 6));
    append_epilogue();
  endtask

  task load_use_program();
    prog.delete();
    emit(i_type(3'b010, 1, 0, 'h10, `OP_LOAD));
    emit(r_type(`F3_ADD, 1'b0, 2, 1, 1)); // uses the load right away
    emit(i_type(3'b010, 3, 0, 'h14, `OP_LOAD));
    emit(s_type(3, 0, 'h20));              // loaded value as store data
    emit(i_type(3'b010, 4, 0, 'h20, `OP_LOAD));
    emit(i_type(`F3_ADD, 5, 4, 1, `OP_ARITH_IMM));
    emit(s_type(5, 0, 'h24));
    emit(i_type(3'b010, 6, 0, 'h24, `OP_LOAD));
    emit(i_type(3'b010, 7, 0, 'h18, `OP_LOAD));
    emit(r_type(`F3_ADD, 1'b1, 7, 7, 6));
    append_epilogue();
  endtask

  task halt_program();
    prog.delete();
    emit(i_type(`F3_ADD, 17, 0, 5, `OP_ARITH_IMM));
    emit(32'h0000_0073);                   // not the exit code
    emit(i_type(`F3_ADD, 1, 0, 33, `OP_ARITH_IMM));
    emit(s_type(1, 0, 'h30));
    append_epilogue();
  endtask

  task random_program();
    int kind;
    int sel;
    int rd;
    prog.delete();
    for (int r = 1; r <= 7; r++) begin
      emit(i_type(`F3_ADD, r, 0, rand_bits(12), `OP_ARITH_IMM));
    end
    for (int n = 0; n < 24; n++) begin
      kind = int'(rand_bits(3));
      sel  = int'(rand_bits(3));
      rd   = pick_reg();
      if (kind < 4) begin
        // funct3 3 is not supported, it stands in for sub
        if (sel == 3) emit(r_type(`F3_ADD, 1'b1, rd, pick_reg(), pick_reg()));
        else emit(r_type(3'(sel), 1'b0, rd, pick_reg(), pick_reg()));
      end else if (kind < 6) begin
        case (sel % 4)
          0:       emit(i_type(`F3_ADD, rd, pick_reg(), rand_bits(12), `OP_ARITH_IMM));
          1:       emit(i_type(`F3_XOR, rd, pick_reg(), rand_bits(12), `OP_ARITH_IMM));
          2:       emit(i_type(`F3_OR, rd, pick_reg(), rand_bits(12), `OP_ARITH_IMM));
          default: emit(i_type(`F3_AND, rd, pick_reg(), rand_bits(12), `OP_ARITH_IMM));
        endcase
      end else if (kind == 6) begin
        emit(i_type(3'b010, rd, 0, int'(rand_bits(4)) * 4, `OP_LOAD));
      end else begin
        emit(s_type(rd, 0, int'(rand_bits(4)) * 4));
      end
    end
    append_epilogue();
  endtask

  task load_memories();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : '0; // opcode 0 is a bubble
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] <= fill_word(i);
    end
  endtask

  task run_test(input string name);
    logic exp_halt;
    int   waited;
    exp_halt = reference_run();
    chk0.start_test(name);
    foreach (exp_addr[k]) begin
      chk0.add_expected(exp_addr[k], exp_data[k]);
    end
    @(posedge clk);
    reset <= 1'b1;
    load_memories();
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    waited = 0;
    while (is_halted !== 1'b1 && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (is_halted !== 1'b1) begin
      $display("timeout: %s did not halt within %0d cycles", name, TIMEOUT);
      chk0.report_counts();
      $display("Test failures found");
      $finish;
    end
    repeat (3) @(negedge clk); // room for a store that should not come
    chk0.end_test(exp_halt);
  endtask

  initial begin
    reset = 1'b1;
    prog.delete();
    load_memories();
    reset_program();
    run_test("reset_state");
    chain_program();
    run_test("dependent_chains");
    load_use_program();
    run_test("load_use");
    halt_program();
    run_test("ecall_halt");
    for (int t = 0; t < 50; t++) begin
      random_program();
      run_test($sformatf("random_%0d", t));
    end
    chk0.report_counts();
    if (chk0.errors_total() == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/bypass_if.sv
hdl/regfile.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/rv_core.sv
dv/rv_checker.sv
dv/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_top -f compile.f -o tb_sim
./obj_dir/tb_sim > sim.log
cat sim.log
if grep -q "Test failures found" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation clean"
